//--- pipeCpu.f
+incdir+rtl
rtl/pipeCpuPkg.sv
rtl/hazardDetect.sv
rtl/runControl.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipeCpu.sv
verification/pipeCpuChecker.sv
verification/pipeCpuTb.sv

//--- Makefile
# Verilator simulation of the pipelined core

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module pipeCpuTb -Mdir obj_dir -f pipeCpu.f
	./obj_dir/VpipeCpuTb | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/pipeCpuTb.sv
// Testbench top for the pipelined core, loads programs, runs them and predicts results
`include "pipeCpu_settings.svh"

module pipeCpuTb;
	timeunit 1ns;
	timeprecision 1ps;
	import pipeCpuPkg::*;

	localparam int NUM_PROGRAMS = 14;

	logic                clk = 1'b0;
	logic                rstN;
	logic                loadReq;
	logic [`IMEM_AW-1:0] loadAddr;
	word_t               loadData;
	logic                loadAck;
	logic                start;
	logic                halted;
	logic                err;
	logic                wbValid;
	regIdx_t             wbReg;
	word_t               wbData;

	word_t       prog [`IMEM_DEPTH];
	int          progLen;
	word_t       modelReg [8];
	word_t       modelMem [`DMEM_DEPTH];
	bit          modelKnown [`DMEM_DEPTH];
	int unsigned lcgState = 95;
	int          cycleCount = 0;
	int          timeoutLimit = 400 * NUM_PROGRAMS;

	pipeCpu pipeCpu_i (.*);

	pipeCpuChecker pipeCpuChecker_i (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			pipeCpuChecker_i.reportFailure("run hit the cycle limit");
			pipeCpuChecker_i.printSummary();
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic int unsigned lcgNext(input int unsigned range);
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return (lcgState >> 16) % range;
	endfunction

	function automatic word_t encodeR(input opcode_t op, input int rd, input int rs, input int rt);
		return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
	endfunction

	function automatic word_t encodeI(input opcode_t op, input int rt, input int rs, input int imm);
		return {op, 3'(rs), 3'(rt), 5'(imm)};
	endfunction

	function automatic word_t encodeBranch(input int rs, input int off);
		return {OP_BEQZ, 3'(rs), 8'(off)};
	endfunction

	// One instruction on the model state, straight from the instruction-set rules
	function automatic void stepModel(input word_t instr, input int pc, output int nextPc,
			output bit writes, output regIdx_t rd, output word_t val, output bit halt,
			output bit illegal);
		opcode_t op;
		regIdx_t rs;
		regIdx_t rt;
		word_t   imm;
		word_t   off;
		int      addr;
		op = instr[15:11];
		rs = instr[10:8];
		rt = instr[7:5];
		imm = {{11{instr[4]}}, instr[4:0]};
		off = {{8{instr[7]}}, instr[7:0]};
		addr = int'(6'(modelReg[rs] + imm));
		nextPc = (pc + 1) % `IMEM_DEPTH;
		writes = 0;
		rd = instr[4:2];
		val = '0;
		halt = 0;
		illegal = 0;
		case (op)
			OP_ADD: val = modelReg[rs] + modelReg[rt];
			OP_SUB: val = modelReg[rs] - modelReg[rt];
			OP_AND: val = modelReg[rs] & modelReg[rt];
			OP_XOR: val = modelReg[rs] ^ modelReg[rt];
			OP_ADDI: val = modelReg[rs] + imm;
			OP_LD: val = modelMem[addr];
			OP_ST: begin
				modelMem[addr] = modelReg[rt];
				modelKnown[addr] = 1;
			end
			OP_BEQZ: begin
				if (modelReg[rs] == '0) begin
					nextPc = int'(6'(pc + 1 + int'(off)));
				end
			end
			OP_HALT: halt = 1;
			OP_NOP: ;
			default: illegal = 1;
		endcase
		if (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD}) begin
			writes = 1;
			if (op == OP_ADDI || op == OP_LD) begin
				rd = rt;
			end
			modelReg[rd] = val;
		end
	endfunction

	// Runs the loaded program to HALT, queues expected writes, returns expected err
	function automatic bit runInstructionSet();
		int      pc;
		int      nextPc;
		int      steps;
		bit      writes;
		bit      halt;
		bit      illegal;
		bit      anyIllegal;
		regIdx_t rd;
		word_t   val;
		pc = 0;
		steps = 0;
		halt = 0;
		anyIllegal = 0;
		while (!halt && steps < 200) begin
			stepModel(prog[pc], pc, nextPc, writes, rd, val, halt, illegal);
			if (writes) begin
				pipeCpuChecker_i.expectWrite(rd, val);
			end
			anyIllegal |= illegal;
			pc = nextPc;
			steps++;
		end
		return anyIllegal;
	endfunction

	// Random straight-line program, loads only from addresses already stored
	function automatic void buildRandomProgram();
		word_t   savedReg [8];
		word_t   savedMem [`DMEM_DEPTH];
		bit      savedKnown [`DMEM_DEPTH];
		word_t   instr;
		int      kind;
		int      addr;
		int      nextPc;
		bit      writes;
		bit      halt;
		bit      illegal;
		regIdx_t rd;
		word_t   val;
		savedReg = modelReg;
		savedMem = modelMem;
		savedKnown = modelKnown;
		progLen = 10 + lcgNext(10);
		for (int i = 0; i < progLen - 1; i++) begin
			kind = lcgNext(8);
			if (kind < 4) begin
				instr = encodeR(opcode_t'(OP_ADD + kind), lcgNext(8), lcgNext(8), lcgNext(8));
			end else if (kind < 6) begin
				instr = encodeI(OP_ADDI, lcgNext(8), lcgNext(8), lcgNext(32));
			end else begin
				instr = encodeI(kind == 6 ? OP_LD : OP_ST, lcgNext(8), lcgNext(8), lcgNext(32));
			end
			addr = int'(6'(modelReg[instr[10:8]] + {{11{instr[4]}}, instr[4:0]}));
			if (instr[15:11] == OP_LD && !modelKnown[addr]) begin
				instr[15:11] = OP_ST;
			end
			prog[i] = instr;
			stepModel(instr, i, nextPc, writes, rd, val, halt, illegal);
		end
		prog[progLen - 1] = {OP_HALT, 11'b0};
		modelReg = savedReg;
		modelMem = savedMem;
		modelKnown = savedKnown;
	endfunction

	task automatic loadWord(input logic [`IMEM_AW-1:0] addr, input word_t data);
		if (loadAck) begin
			pipeCpuChecker_i.reportFailure("loadAck already high before a request");
		end
		loadAddr = addr;
		loadData = data;
		loadReq = 1'b1;
		do @(negedge clk); while (!loadAck);
		loadReq = 1'b0;
		do @(negedge clk); while (loadAck);
	endtask

	task automatic runProgram(input string name);
		bit expErr;
		pipeCpuChecker_i.setTest(name);
		for (int i = 0; i < progLen; i++) begin
			loadWord(`IMEM_AW'(i), prog[i]);
		end
		expErr = runInstructionSet();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		do @(negedge clk); while (!halted);
		repeat (3) @(negedge clk);
		pipeCpuChecker_i.endProgram(expErr);
	endtask

	initial begin
		rstN = 1'b0;
		loadReq = 1'b0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		for (int i = 0; i < 8; i++) begin
			modelReg[i] = '0;
		end
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			modelMem[i] = '0;
			modelKnown[i] = 0;
		end
		repeat (5) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		if (loadAck || halted || err || wbValid) begin
			pipeCpuChecker_i.reportFailure("outputs not idle after reset");
		end

		// Dependent ALU chain
		prog[0] = encodeI(OP_ADDI, 1, 0, 5);
		prog[1] = encodeI(OP_ADDI, 2, 1, -3);
		prog[2] = encodeR(OP_ADD, 3, 1, 2);
		prog[3] = encodeR(OP_SUB, 4, 3, 1);
		prog[4] = encodeR(OP_AND, 5, 4, 3);
		prog[5] = encodeR(OP_XOR, 6, 5, 1);
		prog[6] = encodeR(OP_ADD, 7, 6, 6);
		prog[7] = {OP_HALT, 11'b0};
		progLen = 8;
		runProgram("aluChain");

		// Store then load, loaded value used at once
		prog[0] = encodeI(OP_ADDI, 1, 0, 7);
		prog[1] = encodeI(OP_ADDI, 2, 0, 9);
		prog[2] = encodeI(OP_ST, 2, 1, 3);
		prog[3] = encodeI(OP_LD, 3, 1, 3);
		prog[4] = encodeR(OP_ADD, 4, 3, 3);
		prog[5] = encodeI(OP_ST, 4, 0, 12);
		prog[6] = encodeI(OP_LD, 5, 0, 12);
		prog[7] = {OP_HALT, 11'b0};
		progLen = 8;
		runProgram("storeLoad");

		// Taken branch skips two, then one not taken
		prog[0] = encodeR(OP_XOR, 1, 1, 1);
		prog[1] = encodeBranch(1, 2);
		prog[2] = encodeI(OP_ADDI, 2, 0, 1);
		prog[3] = encodeI(OP_ADDI, 3, 0, 2);
		prog[4] = encodeI(OP_ADDI, 4, 0, 3);
		prog[5] = encodeI(OP_ADDI, 5, 0, 1);
		prog[6] = encodeBranch(5, 2);
		prog[7] = encodeI(OP_ADDI, 6, 0, 4);
		prog[8] = encodeI(OP_ADDI, 7, 0, 5);
		prog[9] = {OP_HALT, 11'b0};
		progLen = 10;
		runProgram("branch");

		// Unused opcode between legal writes
		prog[0] = encodeI(OP_ADDI, 1, 0, 3);
		prog[1] = {5'b11111, 11'b0};
		prog[2] = encodeI(OP_ADDI, 2, 1, 1);
		prog[3] = {OP_HALT, 11'b0};
		progLen = 4;
		runProgram("illegalOp");

		for (int p = 0; p < 10; p++) begin
			buildRandomProgram();
			runProgram($sformatf("random%0d", p));
		end

		pipeCpuChecker_i.printSummary();
		if (pipeCpuChecker_i.totalErrors() == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verification/pipeCpuChecker.sv
// Testbench checker that compares the writeback trace, err and halted with expected values
module pipeCpuChecker (
	input logic                clk,
	input logic                rstN,
	input logic                loadReq,
	input logic                loadAck,
	input logic                halted,
	input logic                err,
	input logic                wbValid,
	input pipeCpuPkg::regIdx_t wbReg,
	input pipeCpuPkg::word_t   wbData
);
	timeunit 1ns;
	timeprecision 1ps;
	import pipeCpuPkg::*;

	regIdx_t expRegQ [$];
	word_t   expDataQ [$];
	string   testName = "none";
	int      valueErrors = 0;
	int      otherErrors = 0;
	logic    prevReq = 1'b0;
	logic    prevAck = 1'b0;

	function automatic void setTest(input string name);
		testName = name;
	endfunction

	function automatic void expectWrite(input regIdx_t r, input word_t d);
		expRegQ.push_back(r);
		expDataQ.push_back(d);
	endfunction

	function automatic void reportFailure(input string msg);
		otherErrors++;
		$display("%s: %s", testName, msg);
	endfunction

	// Called once a program has halted and settled
	function automatic void endProgram(input logic expErr);
		if (expRegQ.size() != 0) begin
			reportFailure($sformatf("%0d expected writes never appeared", expRegQ.size()));
		end
		if (err !== expErr) begin
			valueErrors++;
			$display("CHECK FAILED %s err expected %0b actual %0b", testName, expErr, err);
		end
		expRegQ.delete();
		expDataQ.delete();
	endfunction

	function automatic int totalErrors();
		return valueErrors + otherErrors;
	endfunction

	function automatic void printSummary();
		$display("Summary: %0d value errors, %0d other failures", valueErrors, otherErrors);
	endfunction

	// Writeback trace against the reference queue
	always @(posedge clk) begin
		if (rstN && wbValid) begin
			if (halted) begin
				reportFailure("register write seen while halted");
			end else if (expRegQ.size() == 0) begin
				reportFailure($sformatf("unexpected write r%0d = %h", wbReg, wbData));
			end else begin
				if (wbReg !== expRegQ[0] || wbData !== expDataQ[0]) begin
					valueErrors++;
					$display("CHECK FAILED %s write expected r%0d=%h actual r%0d=%h",
						testName, expRegQ[0], expDataQ[0], wbReg, wbData);
				end
				void'(expRegQ.pop_front());
				void'(expDataQ.pop_front());
			end
		end
	end

	// Four-phase load rules
	always @(posedge clk) begin
		if (rstN) begin
			if (loadAck && !prevAck && !prevReq) begin
				reportFailure("loadAck rose without a pending loadReq");
			end
			if (loadAck && prevAck && !prevReq) begin
				reportFailure("loadAck stayed high after loadReq fell");
			end
		end
		prevReq <= loadReq;
		prevAck <= loadAck;
	end

endmodule

//--- rtl/pipeCpu.sv
// Top level of the five-stage pipelined core, connecting run control and the pipeline stages
`include "pipeCpu_settings.svh"

module pipeCpu (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  loadReq,
	input  logic [`IMEM_AW-1:0]   loadAddr,
	input  pipeCpuPkg::word_t     loadData,
	output logic                  loadAck,
	input  logic                  start,
	output logic                  halted,
	output logic                  err,
	output logic                  wbValid,
	output pipeCpuPkg::regIdx_t   wbReg,
	output pipeCpuPkg::word_t     wbData
);
	import pipeCpuPkg::*;

	// Run control to fetch
	logic                imemWe;
	logic [`IMEM_AW-1:0] imemAddr;
	word_t               imemData;
	logic                run;
	logic                fetchRestart;
	logic                haltSeen;

	// Fetch to decode
	logic                ifValid;
	word_t               ifInstr;
	logic [`IMEM_AW-1:0] ifPc;
	logic                stall;
	logic                flush;
	logic [`IMEM_AW-1:0] branchTarget;

	// Decode sources for hazard checks
	regIdx_t             srcA;
	regIdx_t             srcB;
	logic                useA;
	logic                useB;

	// Decode to execute
	logic                exValid;
	aluOp_t              exAluOp;
	word_t               exOperandA;
	word_t               exOperandB;
	word_t               exStoreData;
	regIdx_t             exDest;
	logic                exWrites;
	logic                exMemRead;
	logic                exMemWrite;
	logic                exHalt;

	// Execute to memory
	logic                memValid;
	word_t               memResult;
	word_t               memStoreData;
	regIdx_t             memDest;
	logic                memWrites;
	logic                memRead;
	logic                memWrite;
	logic                memHalt;

	runControl runControl_i (.*);

	fetchStage fetchStage_i (.*);

	decodeStage decodeStage_i (.*);

	hazardDetect hazardDetect_i (.*);

	executeStage executeStage_i (.*);

	memoryStage memoryStage_i (.*);

endmodule

//--- rtl/memoryStage.sv
// Memory stage with data memory, writeback select and the register that drives writeback
`include "pipeCpu_settings.svh"

module memoryStage (
	input  logic                clk,
	input  logic                rstN,
	input  logic                memValid,
	input  pipeCpuPkg::word_t   memResult,
	input  pipeCpuPkg::word_t   memStoreData,
	input  pipeCpuPkg::regIdx_t memDest,
	input  logic                memWrites,
	input  logic                memRead,
	input  logic                memWrite,
	input  logic                memHalt,
	output logic                wbValid,
	output pipeCpuPkg::regIdx_t wbReg,
	output pipeCpuPkg::word_t   wbData,
	output logic                haltSeen
);
	import pipeCpuPkg::*;

	word_t               dmem [`DMEM_DEPTH];
	logic [`DMEM_AW-1:0] addr;
	word_t               loadWord;

	// Low bits of the ALU sum address the data memory
	assign addr = memResult[`DMEM_AW-1:0];
	assign loadWord = dmem[addr];

	always_ff @(posedge clk) begin
		if (memValid && memWrite) begin
			dmem[addr] <= memStoreData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			haltSeen <= 1'b0;
		end else begin
			wbValid <= memValid && memWrites;
			haltSeen <= memValid && memHalt;
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= memDest;
		wbData <= memRead ? loadWord : memResult;
	end

	// Decode never issues an instruction that both loads and stores
	assert property (@(posedge clk) disable iff (!rstN)
		memValid |-> !(memRead && memWrite));

endmodule

//--- rtl/executeStage.sv
// Execute stage, ALU for results and data addresses plus the execute-to-memory register
module executeStage (
	input  logic                clk,
	input  logic                rstN,
	input  logic                exValid,
	input  pipeCpuPkg::aluOp_t  exAluOp,
	input  pipeCpuPkg::word_t   exOperandA,
	input  pipeCpuPkg::word_t   exOperandB,
	input  pipeCpuPkg::word_t   exStoreData,
	input  pipeCpuPkg::regIdx_t exDest,
	input  logic                exWrites,
	input  logic                exMemRead,
	input  logic                exMemWrite,
	input  logic                exHalt,
	output logic                memValid,
	output pipeCpuPkg::word_t   memResult,
	output pipeCpuPkg::word_t   memStoreData,
	output pipeCpuPkg::regIdx_t memDest,
	output logic                memWrites,
	output logic                memRead,
	output logic                memWrite,
	output logic                memHalt
);
	import pipeCpuPkg::*;

	word_t aluOut;

	always_comb begin
		unique case (exAluOp)
			ALU_ADD: aluOut = exOperandA + exOperandB;
			ALU_SUB: aluOut = exOperandA - exOperandB;
			ALU_AND: aluOut = exOperandA & exOperandB;
			ALU_XOR: aluOut = exOperandA ^ exOperandB;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memValid <= 1'b0;
		end else begin
			memValid <= exValid;
		end
	end

	always_ff @(posedge clk) begin
		memResult <= aluOut;
		memStoreData <= exStoreData;
		memDest <= exDest;
		memWrites <= exWrites;
		memRead <= exMemRead;
		memWrite <= exMemWrite;
		memHalt <= exHalt;
	end

endmodule

//--- rtl/decodeStage.sv
// Decode stage with register file, branch resolution and the decode-to-execute register
`include "pipeCpu_settings.svh"

module decodeStage (
	input  logic                clk,
	input  logic                rstN,
	input  logic                fetchRestart,
	input  logic                ifValid,
	input  pipeCpuPkg::word_t   ifInstr,
	input  logic [`IMEM_AW-1:0] ifPc,
	input  logic                stall,
	input  logic                wbValid,
	input  pipeCpuPkg::regIdx_t wbReg,
	input  pipeCpuPkg::word_t   wbData,
	output logic                flush,
	output logic [`IMEM_AW-1:0] branchTarget,
	output pipeCpuPkg::regIdx_t srcA,
	output pipeCpuPkg::regIdx_t srcB,
	output logic                useA,
	output logic                useB,
	output logic                exValid,
	output pipeCpuPkg::aluOp_t  exAluOp,
	output pipeCpuPkg::word_t   exOperandA,
	output pipeCpuPkg::word_t   exOperandB,
	output pipeCpuPkg::word_t   exStoreData,
	output pipeCpuPkg::regIdx_t exDest,
	output logic                exWrites,
	output logic                exMemRead,
	output logic                exMemWrite,
	output logic                exHalt,
	output logic                err
);
	import pipeCpuPkg::*;

	word_t   regFile [8];
	opcode_t op;
	regIdx_t dest;
	word_t   immExt;
	word_t   readA;
	word_t   readB;
	logic    decValid;
	logic    halting;
	logic    rType;
	logic    needA;
	logic    needB;
	logic    writes;
	logic    memRd;
	logic    memWr;
	logic    isBranch;
	logic    isHalt;
	logic    illegal;

	assign op = ifInstr[15:11];
	assign srcA = ifInstr[10:8];
	assign srcB = ifInstr[7:5];
	assign immExt = {{11{ifInstr[4]}}, ifInstr[4:0]};

	// Everything fetched behind a HALT is dropped here
	assign decValid = ifValid && !halting;

	// Same-cycle writeback bypass
	assign readA = (wbValid && wbReg == srcA) ? wbData : regFile[srcA];
	assign readB = (wbValid && wbReg == srcB) ? wbData : regFile[srcB];

	always_comb begin
		rType = 1'b0;
		needA = 1'b1;
		needB = 1'b0;
		writes = 1'b0;
		dest = ifInstr[4:2];
		memRd = 1'b0;
		memWr = 1'b0;
		isBranch = 1'b0;
		isHalt = 1'b0;
		illegal = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
				rType = 1'b1;
				needB = 1'b1;
				writes = 1'b1;
			end
			OP_ADDI, OP_LD: begin
				writes = 1'b1;
				dest = srcB;
				memRd = (op == OP_LD);
			end
			OP_ST: begin
				needB = 1'b1;
				memWr = 1'b1;
			end
			OP_BEQZ: isBranch = 1'b1;
			OP_HALT: begin
				needA = 1'b0;
				isHalt = 1'b1;
			end
			OP_NOP: needA = 1'b0;
			default: begin
				needA = 1'b0;
				illegal = 1'b1;
			end
		endcase
	end

	assign useA = decValid && needA;
	assign useB = decValid && needB;

	// Branch resolves here and wraps within instruction memory
	assign flush = decValid && isBranch && (readA == '0) && !stall;
	assign branchTarget = ifPc + `IMEM_AW'(1) + ifInstr[`IMEM_AW-1:0];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbValid) begin
			regFile[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid <= 1'b0;
			halting <= 1'b0;
			err <= 1'b0;
		end else if (fetchRestart) begin
			exValid <= 1'b0;
			halting <= 1'b0;
			err <= 1'b0;
		end else begin
			// Stall sends a bubble downstream
			exValid <= decValid && !stall;
			if (decValid && isHalt) begin
				halting <= 1'b1;
			end
			if (decValid && illegal) begin
				err <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		exAluOp <= rType ? aluOp_t'(op[1:0]) : ALU_ADD;
		exOperandA <= readA;
		exOperandB <= rType ? readB : immExt;
		exStoreData <= readB;
		exDest <= dest;
		exWrites <= writes;
		exMemRead <= memRd;
		exMemWrite <= memWr;
		exHalt <= isHalt;
	end

	// A taken branch leaves a bubble behind it in fetch
	assert property (@(posedge clk) disable iff (!rstN)
		flush |=> !ifValid);

	// A held instruction is presented again on the next clock
	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> (ifValid && $stable(ifInstr)));

endmodule

//--- rtl/fetchStage.sv
// Fetch stage with program counter, instruction memory and the fetch-to-decode register
`include "pipeCpu_settings.svh"

module fetchStage (
	input  logic                clk,
	input  logic                rstN,
	input  logic                run,
	input  logic                fetchRestart,
	input  logic                imemWe,
	input  logic [`IMEM_AW-1:0] imemAddr,
	input  pipeCpuPkg::word_t   imemData,
	input  logic                stall,
	input  logic                flush,
	input  logic [`IMEM_AW-1:0] branchTarget,
	output logic                ifValid,
	output pipeCpuPkg::word_t   ifInstr,
	output logic [`IMEM_AW-1:0] ifPc
);
	import pipeCpuPkg::*;

	word_t               imem [`IMEM_DEPTH];
	logic [`IMEM_AW-1:0] pc;

	// Written only by the loader
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ifValid <= 1'b0;
		end else if (fetchRestart) begin
			pc <= '0;
			ifValid <= 1'b0;
		end else if (flush) begin
			// Taken branch, drop the wrong-path fetch
			pc <= branchTarget;
			ifValid <= 1'b0;
		end else if (!stall) begin
			ifValid <= run;
			if (run) begin
				pc <= pc + `IMEM_AW'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifInstr <= imem[pc];
			ifPc <= pc;
		end
	end

endmodule

//--- rtl/runControl.sv
// Program loader and run sequencer that answers the four-phase load and starts and stops fetch
`include "pipeCpu_settings.svh"

module runControl (
	input  logic                clk,
	input  logic                rstN,
	input  logic                loadReq,
	input  logic [`IMEM_AW-1:0] loadAddr,
	input  pipeCpuPkg::word_t   loadData,
	input  logic                start,
	input  logic                haltSeen,
	output logic                loadAck,
	output logic                imemWe,
	output logic [`IMEM_AW-1:0] imemAddr,
	output pipeCpuPkg::word_t   imemData,
	output logic                run,
	output logic                fetchRestart,
	output logic                halted
);
	import pipeCpuPkg::*;

	loadState_t state;
	loadState_t nextState;
	logic       stopped;

	// Loads and starts are only taken while the core is stopped
	assign stopped = (state == IDLE) || (state == HALTED);
	assign run = (state == RUN);
	assign loadAck = (state == ACK);
	assign fetchRestart = stopped && start;
	assign imemWe = stopped && loadReq && !start;
	assign imemAddr = loadAddr;
	assign imemData = loadData;

	always_comb begin
		nextState = state;
		case (state)
			IDLE, HALTED: begin
				if (start) begin
					nextState = RUN;
				end else if (loadReq) begin
					nextState = ACK;
				end
			end
			ACK: begin
				// Back to whichever stopped state the load came from
				if (!loadReq) begin
					nextState = halted ? HALTED : IDLE;
				end
			end
			RUN: begin
				if (haltSeen) begin
					nextState = HALTED;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			halted <= 1'b0;
		end else begin
			state <= nextState;
			if (fetchRestart) begin
				halted <= 1'b0;
			end else if (run && haltSeen) begin
				halted <= 1'b1;
			end
		end
	end

	// Acknowledge only answers a request seen on the previous clock
	assert property (@(posedge clk) disable iff (!rstN)
		$rose(loadAck) |-> $past(loadReq));

	// Each instruction write is acknowledged on the next clock
	assert property (@(posedge clk) disable iff (!rstN)
		imemWe |=> loadAck);

endmodule

//--- rtl/hazardDetect.sv
// Register dependence check between decode and the execute and memory stages, raises stall
module hazardDetect (
	input  pipeCpuPkg::regIdx_t srcA,
	input  pipeCpuPkg::regIdx_t srcB,
	input  logic                useA,
	input  logic                useB,
	input  logic                exValid,
	input  pipeCpuPkg::regIdx_t exDest,
	input  logic                exWrites,
	input  logic                memValid,
	input  pipeCpuPkg::regIdx_t memDest,
	input  logic                memWrites,
	output logic                stall
);

	logic exPending;
	logic memPending;
	logic hitA;
	logic hitB;

	// Writes still ahead of writeback, the writeback itself is bypassed
	assign exPending = exValid && exWrites;
	assign memPending = memValid && memWrites;

	assign hitA = useA && ((exPending && exDest == srcA) || (memPending && memDest == srcA));
	assign hitB = useB && ((exPending && exDest == srcB) || (memPending && memDest == srcB));

	assign stall = hitA || hitB;

endmodule

//--- rtl/pipeCpuPkg.sv
// Shared types, opcode encodings and FSM states for the pipelined core and its testbench
package pipeCpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0]  regIdx_t;
	typedef logic [4:0]  opcode_t;

	// Opcode field, instruction bits 15 to 11
	localparam opcode_t OP_HALT = 5'b00000;
	localparam opcode_t OP_NOP  = 5'b00001;
	// R-type group, low two bits pick the ALU function
	localparam opcode_t OP_ADD  = 5'b00100;
	localparam opcode_t OP_SUB  = 5'b00101;
	localparam opcode_t OP_AND  = 5'b00110;
	localparam opcode_t OP_XOR  = 5'b00111;
	localparam opcode_t OP_ADDI = 5'b01000;
	localparam opcode_t OP_BEQZ = 5'b01100;
	localparam opcode_t OP_LD   = 5'b10000;
	localparam opcode_t OP_ST   = 5'b10001;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_XOR
	} aluOp_t;

	// Program load and run sequencing
	typedef enum logic [1:0] {
		IDLE,
		ACK,
		RUN,
		HALTED
	} loadState_t;

endpackage

//--- rtl/pipeCpu_settings.svh
// Memory sizes and address widths of the pipelined core, included by the RTL that needs them
`ifndef PIPECPU_SETTINGS_SVH
`define PIPECPU_SETTINGS_SVH

// Instruction memory, in 16-bit words
`define IMEM_DEPTH 64
`define IMEM_AW    6

// Data memory, in 16-bit words
`define DMEM_DEPTH 64
`define DMEM_AW    6

`endif
